/* source/vis_cfg_pkg.sv */
`default_nettype none

// sizing of the correlator array and the widths that follow from it
package vis_cfg_pkg;

   localparam int NANT   = 4;                  // antennas
   localparam int NCORR  = NANT * (NANT - 1) / 2; // one correlator per antenna pair
   localparam int WINDOW = 64;                 // valid samples per window
   localparam int ACC_W  = 24;                 // accumulator / bus word width
   localparam int WCNT_W = $clog2(WINDOW + 1); // window counter
   localparam int NWORD  = 2 * NCORR;          // re + im per correlator
   localparam int BADR_W = $clog2(NWORD * 4);  // host byte address, 4 lanes per word

   // ---------------------------------------------------------------------
   // pair enumeration (0,1) (0,2) .. (0,n-1) (1,2) ..
   // ---------------------------------------------------------------------
   function automatic int pair_idx(input int idx, input int nant, input bit want_b);
      int k;
      k = 0;
      for (int a = 0; a < nant; a++) begin
         for (int b = a + 1; b < nant; b++) begin
            if (k == idx)
               return want_b ? b : a;
            k++;
         end
      end
      return 0;                                // idx out of range
   endfunction

   function automatic int pair_a(input int idx, input int nant);
      return pair_idx(idx, nant, 1'b0);
   endfunction

   function automatic int pair_b(input int idx, input int nant);
      return pair_idx(idx, nant, 1'b1);
   endfunction

endpackage

`default_nettype wire

/* source/vis_bus_pkg.sv */
`default_nettype none

// readout bus payload between prefetcher and correlators
package vis_bus_pkg;

   import vis_cfg_pkg::*;

   typedef logic [ACC_W-1:0] vis_word_t;       // one visibility count

   // which bank word a strobe asks for
   typedef enum logic {
      PART_RE = 1'b0,                          // I(a) == I(b) count
      PART_IM = 1'b1                           // I(a) == Q(b) count
   } part_e;

endpackage

`default_nettype wire

/* source/corr_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// cyc/stb/ack readout bus, one per correlator
//   stb is a single-cycle request, ack + dat come back the cycle after
interface corr_bus_if
   import vis_bus_pkg::*;
();

   logic      cyc;                             // held for the whole prefetch
   logic      stb;                             // one-cycle request
   part_e     part;                            // re or im bank word
   logic      ack;                             // reply strobe
   vis_word_t dat;                             // reply data, valid with ack

   modport master (
      output cyc, stb, part,
      input  ack, dat
   );

   modport slave (
      input  cyc, stb, part,
      output ack, dat
   );

endinterface

`default_nettype wire

/* source/samp_if.sv */
`timescale 1ns/1ps
`default_nettype none

// sample broadcast from the fanout to every correlator
interface samp_if
   import vis_cfg_pkg::*;
#(
   parameter int N_ANT = NANT
) ();

   logic             valid;                    // sample strobe, level per cycle
   logic [N_ANT-1:0] i_bits;                   // one-bit in-phase per antenna
   logic [N_ANT-1:0] q_bits;                   // one-bit quadrature per antenna
   logic             switch;                   // with the last valid of a window

   modport src (output valid, i_bits, q_bits, switch);
   modport dst (input  valid, i_bits, q_bits, switch);

endinterface

`default_nettype wire

/* source/sample_fanout.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_fanout
   import vis_cfg_pkg::*;
#(
   parameter int NANT   = vis_cfg_pkg::NANT,
   parameter int WINDOW = vis_cfg_pkg::WINDOW
) (
   input  logic            clk_i,
   input  logic            rst_i,
   input  logic            samp_valid_i,
   input  logic [NANT-1:0] samp_i_i,
   input  logic [NANT-1:0] samp_q_i,
   samp_if.src             samp_o
);

   logic [WCNT_W-1:0] wcnt;                    // valid samples seen in this window
   logic              last;                    // next valid closes the window

   assign last = (wcnt == WCNT_W'(WINDOW - 1));

   // ---------------------------------------------------------------------
   // window counter and broadcast strobes, one cycle behind the inputs
   // ---------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wcnt          <= '0;
         samp_o.valid  <= 1'b0;
         samp_o.switch <= 1'b0;
      end else begin
         samp_o.valid  <= samp_valid_i;
         samp_o.switch <= samp_valid_i & last;  // lines up with the closing valid
         if (samp_valid_i)
            wcnt <= last ? '0 : wcnt + 1'b1;    // wraps modulo WINDOW
      end
   end

   // raw sample bits, meaningful only with valid
   always_ff @(posedge clk_i) begin
      samp_o.i_bits <= samp_i_i;
      samp_o.q_bits <= samp_q_i;
   end

endmodule

`default_nettype wire

/* source/correlator.sv */
`timescale 1ns/1ps
`default_nettype none

// one antenna pair: counts sign agreements, banks them at each switch
module correlator
   import vis_bus_pkg::*;
#(
   parameter int ACC_W = vis_cfg_pkg::ACC_W,
   parameter int IDX_A = 0,                    // first antenna of the pair
   parameter int IDX_B = 1                     // second antenna of the pair
) (
   input  logic      clk_i,
   input  logic      rst_i,
   samp_if.dst       samp_i,
   corr_bus_if.slave bus_s
);

   logic [ACC_W-1:0] acc_re;                   // running real count
   logic [ACC_W-1:0] acc_im;                   // running imaginary count
   logic [ACC_W-1:0] sum_re;                   // count including this sample
   logic [ACC_W-1:0] sum_im;
   logic             agree_re;
   logic             agree_im;
   vis_word_t        bank_re;                  // totals of the last finished window
   vis_word_t        bank_im;

   // one-bit correlation is just equality of the signs
   assign agree_re = (samp_i.i_bits[IDX_A] == samp_i.i_bits[IDX_B]);
   assign agree_im = (samp_i.i_bits[IDX_A] == samp_i.q_bits[IDX_B]);

   assign sum_re = acc_re + ACC_W'(agree_re);
   assign sum_im = acc_im + ACC_W'(agree_im);

   // ---------------------------------------------------------------------
   // accumulators
   // ---------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         acc_re <= '0;
         acc_im <= '0;
      end else if (samp_i.valid) begin
         if (samp_i.switch) begin              // window done, start over
            acc_re <= '0;
            acc_im <= '0;
         end else begin
            acc_re <= sum_re;
            acc_im <= sum_im;
         end
      end
   end

   // bank takes the totals with the closing sample folded in
   always_ff @(posedge clk_i) begin
      if (samp_i.valid && samp_i.switch) begin
         bank_re <= vis_word_t'(sum_re);
         bank_im <= vis_word_t'(sum_im);
      end
   end

   // ---------------------------------------------------------------------
   // bus slave, answers every strobe one cycle later
   // ---------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i)
         bus_s.ack <= 1'b0;
      else
         bus_s.ack <= bus_s.cyc & bus_s.stb;
   end

   always_ff @(posedge clk_i) begin
      if (bus_s.stb)
         bus_s.dat <= (bus_s.part == PART_IM) ? bank_im : bank_re;
   end

endmodule

`default_nettype wire

/* source/vis_prefetch.sv */
`timescale 1ns/1ps
`default_nettype none

// walks all correlator banks after a switch and copies them to the buffer
module vis_prefetch
   import vis_cfg_pkg::*, vis_bus_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              switch_i,
   corr_bus_if.master        bus_m [NCORR],
   output logic              wr_en_o,
   output logic [BADR_W-3:0] wr_adr_o,
   output vis_word_t         wr_dat_o,
   output logic              ready_o,
   output vis_word_t         checksum_o
);

   localparam int SEL_W = BADR_W - 3;          // word number without the part bit

   typedef enum logic [1:0] {
      ST_IDLE,                                 // nothing to fetch
      ST_REQ,                                  // strobe out this cycle
      ST_WAIT                                  // waiting for ack
   } state_t;

   state_t            state;
   logic [BADR_W-3:0] word;                    // buffer word, 2*corr + part
   logic [SEL_W-1:0]  sel;                     // correlator being read
   logic [NCORR-1:0]  ack_v;
   vis_word_t         dat_v [NCORR];
   logic              ack;
   logic              last;

   assign sel  = word[BADR_W-3:1];
   assign ack  = ack_v[sel];
   assign last = (word == (BADR_W - 2)'(NWORD - 1));

   // ---------------------------------------------------------------------
   // fan the single master out over the bus array
   // ---------------------------------------------------------------------
   for (genvar g = 0; g < NCORR; g++) begin : g_bus
      assign bus_m[g].cyc  = (state != ST_IDLE);
      assign bus_m[g].stb  = (state == ST_REQ) && (sel == SEL_W'(g));
      assign bus_m[g].part = part_e'(word[0]);
      assign ack_v[g]      = bus_m[g].ack;
      assign dat_v[g]      = bus_m[g].dat;
   end

   // buffer write straight off the ack
   assign wr_en_o  = ack && (state == ST_WAIT);
   assign wr_adr_o = word;
   assign wr_dat_o = dat_v[sel];

   // ---------------------------------------------------------------------
   // fetch FSM, two cycles per word
   // ---------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state      <= ST_IDLE;
         word       <= '0;
         ready_o    <= 1'b0;
         checksum_o <= '0;
      end else if (switch_i) begin             // new banks, old buffer is stale
         state      <= ST_REQ;
         word       <= '0;
         ready_o    <= 1'b0;
         checksum_o <= '0;
      end else begin
         case (state)
            ST_REQ: state <= ST_WAIT;
            ST_WAIT: begin
               if (ack) begin
                  checksum_o <= checksum_o ^ dat_v[sel];
                  if (last) begin
                     state   <= ST_IDLE;
                     ready_o <= 1'b1;          // held until the next switch
                  end else begin
                     state <= ST_REQ;
                     word  <= word + 1'b1;
                  end
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

/* source/vis_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

// word-wide write from the prefetcher, byte-wide read for the host
module vis_buffer
   import vis_cfg_pkg::*, vis_bus_pkg::*;
(
   input  logic              clk_i,
   input  logic              wr_en_i,
   input  logic [BADR_W-3:0] wr_adr_i,
   input  vis_word_t         wr_dat_i,
   input  logic [BADR_W-1:0] rd_adr_i,      // {word, lane}
   output logic [7:0]        rd_dat_o
);

   vis_word_t         mem [NWORD];
   logic [BADR_W-3:0] rd_word;
   logic [1:0]        rd_lane;

   assign rd_word = rd_adr_i[BADR_W-1:2];
   assign rd_lane = rd_adr_i[1:0];

   always_ff @(posedge clk_i) begin
      if (wr_en_i)
         mem[wr_adr_i] <= wr_dat_i;
   end

   // ---------------------------------------------------------------------
   // byte read, lsb first, lane 3 and unused words read as zero
   // ---------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      rd_dat_o <= 8'h00;
      if (rd_word < NWORD && rd_lane != 2'd3)
         rd_dat_o <= mem[rd_word][{rd_lane, 3'b000} +: 8];
   end

endmodule

`default_nettype wire

/* source/vis_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vis_top
   import vis_cfg_pkg::*, vis_bus_pkg::*;
#(
   parameter int NANT   = vis_cfg_pkg::NANT,
   parameter int WINDOW = vis_cfg_pkg::WINDOW,
   parameter int ACC_W  = vis_cfg_pkg::ACC_W
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              samp_valid_i,
   input  logic [NANT-1:0]   samp_i_i,
   input  logic [NANT-1:0]   samp_q_i,
   input  logic [BADR_W-1:0] rd_adr_i,
   output logic [7:0]        rd_dat_o,
   output logic              ready_o,      // buffer holds a full window
   output vis_word_t         checksum_o    // xor of all buffered words
);

   logic              wr_en;
   logic [BADR_W-3:0] wr_adr;
   vis_word_t         wr_dat;

   samp_if #(.N_ANT(NANT)) samp ();
   corr_bus_if             cbus [NCORR] ();

   // ---------------------------------------------------------------------
   // sample path
   // ---------------------------------------------------------------------
   sample_fanout #(
      .NANT   (NANT),
      .WINDOW (WINDOW)
   ) u_fanout (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .samp_valid_i (samp_valid_i),
      .samp_i_i     (samp_i_i),
      .samp_q_i     (samp_q_i),
      .samp_o       (samp)
   );

   for (genvar g = 0; g < NCORR; g++) begin : g_corr
      correlator #(
         .ACC_W (ACC_W),
         .IDX_A (pair_a(g, NANT)),
         .IDX_B (pair_b(g, NANT))
      ) u_corr (
         .clk_i  (clk_i),
         .rst_i  (rst_i),
         .samp_i (samp),
         .bus_s  (cbus[g])
      );
   end

   // ---------------------------------------------------------------------
   // readout path
   // ---------------------------------------------------------------------
   vis_prefetch u_prefetch (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .switch_i   (samp.switch),
      .bus_m      (cbus),
      .wr_en_o    (wr_en),
      .wr_adr_o   (wr_adr),
      .wr_dat_o   (wr_dat),
      .ready_o    (ready_o),
      .checksum_o (checksum_o)
   );

   vis_buffer u_buffer (
      .clk_i    (clk_i),
      .wr_en_i  (wr_en),
      .wr_adr_i (wr_adr),
      .wr_dat_i (wr_dat),
      .rd_adr_i (rd_adr_i),
      .rd_dat_o (rd_dat_o)
   );

endmodule

`default_nettype wire

/* sim/vis_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module vis_tb
   import vis_cfg_pkg::*;
();

   localparam int CYC         = 100;                   // clock period in ns
   localparam int NWIN        = 5;                     // windows in the run
   localparam int TIMEOUT_CYC = NWIN * WINDOW * 4 + 2000;

   logic              clk_i = 1'b0;
   logic              rst_i;
   logic              samp_valid_i;
   logic [NANT-1:0]   samp_i_i;
   logic [NANT-1:0]   samp_q_i;
   logic [BADR_W-1:0] rd_adr_i;
   logic [7:0]        rd_dat_o;
   logic              ready_o;
   logic [ACC_W-1:0]  checksum_o;

   int                pa [NCORR];                      // first antenna of each model pair
   int                pb [NCORR];                      // second antenna
   logic [ACC_W-1:0]  acc_re [NCORR];                  // model accumulators
   logic [ACC_W-1:0]  acc_im [NCORR];
   logic [ACC_W-1:0]  exp_word [NWORD];                // expected buffer contents
   int                nvalid;                          // valid samples in this window

   vis_top #(
      .NANT   (NANT),
      .WINDOW (WINDOW),
      .ACC_W  (ACC_W)
   ) u_dut (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .samp_valid_i (samp_valid_i),
      .samp_i_i     (samp_i_i),
      .samp_q_i     (samp_q_i),
      .rd_adr_i     (rd_adr_i),
      .rd_dat_o     (rd_dat_o),
      .ready_o      (ready_o),
      .checksum_o   (checksum_o)
   );

   always #(CYC / 2) clk_i = ~clk_i;

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("tests failed");
      $fatal(1);
   endtask

   // pairs in order (0,1) (0,2) .. (1,2) ..
   task automatic build_pairs();
      int k;
      k = 0;
      for (int a = 0; a < NANT; a++) begin
         for (int b = a + 1; b < NANT; b++) begin
            pa[k] = a;
            pb[k] = b;
            k++;
         end
      end
   endtask

   // ----------------------------------------------------------------------
   // stimulus and reference model for one clock cycle
   // ----------------------------------------------------------------------
   task automatic drive_sample();
      samp_valid_i = (($urandom % 4) != 0);            // about 75% valid
      samp_i_i     = NANT'($urandom);
      samp_q_i     = NANT'($urandom);
      if (samp_valid_i) begin
         for (int k = 0; k < NCORR; k++) begin
            if (samp_i_i[pa[k]] == samp_i_i[pb[k]])
               acc_re[k] = acc_re[k] + 1'b1;           // real part counts sign agreement
            if (samp_i_i[pa[k]] == samp_q_i[pb[k]])
               acc_im[k] = acc_im[k] + 1'b1;           // imaginary part compares i with q
         end
         nvalid++;
         if (nvalid == WINDOW) begin                   // closing sample banks the counts
            for (int k = 0; k < NCORR; k++) begin
               exp_word[2*k]     = acc_re[k];
               exp_word[2*k + 1] = acc_im[k];
               acc_re[k]         = '0;
               acc_im[k]         = '0;
            end
         end
      end
      @(posedge clk_i);
      #1;
   endtask

   task automatic check_idle();
      assert (ready_o == 1'b0) else
         report_failure($sformatf("FAILED ready_o expected 0 got %h", ready_o));
      assert (checksum_o == '0) else
         report_failure($sformatf("FAILED checksum_o expected 0 got %h", checksum_o));
   endtask

   // xor of every expected buffer word
   function automatic logic [ACC_W-1:0] model_checksum();
      logic [ACC_W-1:0] sum;
      sum = '0;
      for (int w = 0; w < NWORD; w++)
         sum = sum ^ exp_word[w];
      return sum;
   endfunction

   // the banked window stays on offer until the next switch
   task automatic check_ready();
      logic [ACC_W-1:0] sum;
      sum = model_checksum();
      assert (ready_o == 1'b1) else
         report_failure($sformatf("FAILED ready_o expected 1 got %h", ready_o));
      assert (checksum_o == sum) else
         report_failure($sformatf("FAILED checksum_o expected %h got %h", sum, checksum_o));
   endtask

   // ----------------------------------------------------------------------
   // host reads every byte address after the checksum
   // ----------------------------------------------------------------------
   task automatic read_buffer();
      logic [7:0]       exp_byte;
      int               lane;
      check_ready();
      for (int a = 0; a < NWORD * 4; a++) begin
         rd_adr_i = BADR_W'(a);
         @(posedge clk_i);                             // one cycle read latency
         #1;
         lane     = a % 4;
         exp_byte = (lane == 3) ? 8'h00 : exp_word[a / 4][lane*8 +: 8];
         assert (rd_dat_o == exp_byte) else
            report_failure($sformatf("FAILED rd_dat_o at %h expected %h got %h",
                                     a, exp_byte, rd_dat_o));
      end
   endtask

   task automatic run_window(input int w);
      nvalid = 0;
      while (nvalid < WINDOW) begin
         if (w == 0)
            check_idle();                              // nothing banked yet
         else
            check_ready();                             // last window still buffered
         drive_sample();
      end
      samp_valid_i = 1'b0;                             // quiet while the host reads
      if (w > 0) begin
         assert (ready_o == 1'b1) else
            report_failure($sformatf("FAILED ready_o expected 1 got %h", ready_o));
         wait (ready_o == 1'b0);                       // switch clears the buffer
      end
      wait (ready_o == 1'b1);
      @(posedge clk_i);
      #1;
      read_buffer();
   endtask

   initial begin
      #(TIMEOUT_CYC * CYC);
      report_failure("watchdog timeout, the run did not finish in time");
   end

   initial begin
      void'($urandom(32'h5807));
      rst_i        = 1'b1;
      samp_valid_i = 1'b0;
      samp_i_i     = '0;
      samp_q_i     = '0;
      rd_adr_i     = '0;
      nvalid       = 0;
      build_pairs();
      for (int k = 0; k < NCORR; k++) begin
         acc_re[k] = '0;
         acc_im[k] = '0;
      end
      repeat (8) @(posedge clk_i);
      #1;
      rst_i = 1'b0;
      check_idle();
      for (int w = 0; w < NWIN; w++)
         run_window(w);
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

/* vis_top.f */
source/vis_cfg_pkg.sv
source/vis_bus_pkg.sv
source/corr_bus_if.sv
source/samp_if.sv
source/sample_fanout.sv
source/correlator.sv
source/vis_prefetch.sv
source/vis_buffer.sv
source/vis_top.sv
sim/vis_tb.sv

/* Makefile */
VERILATOR  := verilator
VFLAGS     := --binary --timing -j 0 -Wno-fatal
LINT_FLAGS := --lint-only --timing
TOP        := vis_tb
RTL_TOP    := vis_top
FILELIST   := vis_top.f
PASS_MSG   := all tests passed

.PHONY: all lint clean

all:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf obj_dir
